/* src/corr_pkg.sv */
package corr_pkg;

	// Array geometry
	localparam int NUM_INPUTS = 4;
	localparam int SAMPLE_WIDTH = 2;

	// Tap k holds the sample from k strobes ago
	localparam int NUM_LAGS = 4;

	// One baseline per unordered input pair
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;

	// Accumulator sizing
	localparam int ACC_WIDTH = 12;
	localparam logic [ACC_WIDTH-1:0] MAX_COUNT = {ACC_WIDTH{1'b1}};
	localparam int PRODUCT_WIDTH = 2 * SAMPLE_WIDTH;

	// Readout bank
	localparam int NUM_WORDS = NUM_BASELINES * NUM_LAGS;
	localparam int ADDR_WIDTH = 5;

	localparam int INT_LEN_WIDTH = 16;

	// Baseline b correlates input BASELINE_A[b] against delayed input BASELINE_B[b]
	localparam int BASELINE_A [NUM_BASELINES] = '{0, 0, 0, 1, 1, 2};
	localparam int BASELINE_B [NUM_BASELINES] = '{1, 2, 3, 2, 3, 3};

endpackage

/* src/sample_delay_line.sv */
`timescale 1ns/1ps

module sample_delay_line (
	input  logic                                               clk,
	input  logic                                               rst_n_i,
	input  logic                                               sample_stb_i,
	input  logic [corr_pkg::SAMPLE_WIDTH-1:0]                  sample_i,
	output logic [corr_pkg::NUM_LAGS*corr_pkg::SAMPLE_WIDTH-1:0] taps_o,
	output logic                                               tap_valid_o
);

	localparam int TAPS_WIDTH = corr_pkg::NUM_LAGS * corr_pkg::SAMPLE_WIDTH;

	// Newest sample enters at tap 0, older ones move up
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			taps_o <= '0;
		end else if (sample_stb_i) begin
			taps_o <= {taps_o[TAPS_WIDTH-corr_pkg::SAMPLE_WIDTH-1:0], sample_i};
		end
	end

	// Taps are stable with the new sample one cycle after the strobe
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tap_valid_o <= 1'b0;
		end else begin
			tap_valid_o <= sample_stb_i;
		end
	end

endmodule

/* src/baseline_correlator.sv */
`timescale 1ns/1ps

module baseline_correlator (
	input  logic                                                clk,
	input  logic                                                rst_n_i,
	input  logic                                                acc_en_i,
	input  logic                                                acc_clear_i,
	input  logic [corr_pkg::NUM_LAGS*corr_pkg::SAMPLE_WIDTH-1:0] ref_taps_i,
	input  logic [corr_pkg::NUM_LAGS*corr_pkg::SAMPLE_WIDTH-1:0] lag_taps_i,
	output logic [corr_pkg::NUM_LAGS*corr_pkg::ACC_WIDTH-1:0]    acc_o
);

	localparam int SW = corr_pkg::SAMPLE_WIDTH;
	localparam int AW = corr_pkg::ACC_WIDTH;
	localparam int PW = corr_pkg::PRODUCT_WIDTH;

	// Newest sample of the reference input
	logic [SW-1:0] ref_sample;

	assign ref_sample = ref_taps_i[SW-1:0];

	for (genvar k = 0; k < corr_pkg::NUM_LAGS; k++) begin : g_lag
		logic [SW-1:0] lag_sample;
		logic [PW-1:0] product;
		logic [AW:0]   sum;
		logic [AW-1:0] acc_q;

		assign lag_sample = lag_taps_i[k*SW +: SW];

		// Operands widen to the product width before the multiply
		assign product = {{(PW-SW){1'b0}}, ref_sample} * {{(PW-SW){1'b0}}, lag_sample};

		// One spare bit catches the carry out for saturation
		assign sum = {1'b0, acc_q} + {{(AW+1-PW){1'b0}}, product};

		always_ff @(posedge clk or negedge rst_n_i) begin
			if (!rst_n_i) begin
				acc_q <= '0;
			end else if (acc_clear_i) begin
				acc_q <= '0;
			end else if (acc_en_i) begin
				if (sum[AW]) begin
					acc_q <= corr_pkg::MAX_COUNT;
				end else begin
					acc_q <= sum[AW-1:0];
				end
			end
		end

		assign acc_o[k*AW +: AW] = acc_q;
	end

endmodule

/* src/integration_control.sv */
`timescale 1ns/1ps

module integration_control (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic                                 enable_i,
	input  logic                                 tap_valid_i,
	input  logic [corr_pkg::INT_LEN_WIDTH-1:0]   int_len_i,
	output logic                                 acc_en_o,
	output logic                                 acc_clear_o,
	output logic                                 dump_o
);

	logic [corr_pkg::INT_LEN_WIDTH-1:0] count_q;
	logic [corr_pkg::INT_LEN_WIDTH-1:0] count_next;
	logic                               last_set;

	assign acc_en_o = tap_valid_i & enable_i;

	assign count_next = count_q + 1'b1;

	// This accumulate completes the programmed integration length
	assign last_set = (count_next >= int_len_i);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count_q <= '0;
		end else if (acc_clear_o) begin
			count_q <= '0;
		end else if (acc_en_o) begin
			if (last_set) begin
				count_q <= '0;
			end else begin
				count_q <= count_next;
			end
		end
	end

	// Dump follows the final accumulate by one cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dump_o <= 1'b0;
		end else begin
			dump_o <= acc_en_o & last_set;
		end
	end

	// Clear accumulators right after the snapshot, and hold them while disabled
	assign acc_clear_o = dump_o | ~enable_i;

endmodule

/* src/correlation_readout.sv */
`timescale 1ns/1ps

module correlation_readout (
	input  logic                                                 clk,
	input  logic                                                 rst_n_i,
	input  logic                                                 dump_i,
	input  logic [corr_pkg::NUM_WORDS*corr_pkg::ACC_WIDTH-1:0]    acc_i,
	input  logic                                                 rd_stb_i,
	input  logic [corr_pkg::ADDR_WIDTH-1:0]                      rd_addr_i,
	output logic                                                 frame_valid_o,
	output logic                                                 rd_valid_o,
	output logic [corr_pkg::ACC_WIDTH-1:0]                       rd_data_o
);

	localparam int AW = corr_pkg::ACC_WIDTH;

	logic [AW-1:0] bank_q [corr_pkg::NUM_WORDS];
	logic          addr_ok;

	assign addr_ok = (rd_addr_i < corr_pkg::ADDR_WIDTH'(corr_pkg::NUM_WORDS));

	// Snapshot of every accumulator, kept until the next dump
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int w = 0; w < corr_pkg::NUM_WORDS; w++) begin
				bank_q[w] <= '0;
			end
		end else if (dump_i) begin
			for (int w = 0; w < corr_pkg::NUM_WORDS; w++) begin
				bank_q[w] <= acc_i[w*AW +: AW];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			frame_valid_o <= 1'b0;
			rd_valid_o <= 1'b0;
		end else begin
			frame_valid_o <= dump_i;
			rd_valid_o <= rd_stb_i;
		end
	end

	// Unmapped addresses read as zero
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_data_o <= '0;
		end else if (rd_stb_i) begin
			rd_data_o <= addr_ok ? bank_q[rd_addr_i] : '0;
		end
	end

endmodule

/* src/lag_correlator_top.sv */
`timescale 1ns/1ps

module lag_correlator_top (
	input  logic                                                  clk,
	input  logic                                                  rst_n_i,
	input  logic                                                  sample_stb_i,
	input  logic [corr_pkg::NUM_INPUTS*corr_pkg::SAMPLE_WIDTH-1:0] samples_i,
	input  logic                                                  enable_i,
	input  logic [corr_pkg::INT_LEN_WIDTH-1:0]                    int_len_i,
	input  logic                                                  rd_stb_i,
	input  logic [corr_pkg::ADDR_WIDTH-1:0]                       rd_addr_i,
	output logic                                                  frame_valid_o,
	output logic                                                  rd_valid_o,
	output logic [corr_pkg::ACC_WIDTH-1:0]                        rd_data_o
);

	localparam int SW = corr_pkg::SAMPLE_WIDTH;
	localparam int TAPS_WIDTH = corr_pkg::NUM_LAGS * SW;
	localparam int BL_WIDTH = corr_pkg::NUM_LAGS * corr_pkg::ACC_WIDTH;

	logic [TAPS_WIDTH-1:0]                          taps [corr_pkg::NUM_INPUTS];
	logic [corr_pkg::NUM_INPUTS-1:0]                tap_valid;
	logic                                           acc_en;
	logic                                           acc_clear;
	logic                                           dump;
	logic [corr_pkg::NUM_WORDS*corr_pkg::ACC_WIDTH-1:0] acc_all;

	for (genvar i = 0; i < corr_pkg::NUM_INPUTS; i++) begin : g_input
		sample_delay_line u_delay (
			.clk          (clk),
			.rst_n_i      (rst_n_i),
			.sample_stb_i (sample_stb_i),
			.sample_i     (samples_i[i*SW +: SW]),
			.taps_o       (taps[i]),
			.tap_valid_o  (tap_valid[i])
		);
	end

	// Baseline b lands at words b*NUM_LAGS .. b*NUM_LAGS+NUM_LAGS-1
	for (genvar b = 0; b < corr_pkg::NUM_BASELINES; b++) begin : g_baseline
		baseline_correlator u_corr (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.acc_en_i    (acc_en),
			.acc_clear_i (acc_clear),
			.ref_taps_i  (taps[corr_pkg::BASELINE_A[b]]),
			.lag_taps_i  (taps[corr_pkg::BASELINE_B[b]]),
			.acc_o       (acc_all[b*BL_WIDTH +: BL_WIDTH])
		);
	end

	// All lines share one strobe, so line 0 speaks for the rest
	integration_control u_ctrl (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.enable_i    (enable_i),
		.tap_valid_i (tap_valid[0]),
		.int_len_i   (int_len_i),
		.acc_en_o    (acc_en),
		.acc_clear_o (acc_clear),
		.dump_o      (dump)
	);

	correlation_readout u_readout (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.dump_i        (dump),
		.acc_i         (acc_all),
		.rd_stb_i      (rd_stb_i),
		.rd_addr_i     (rd_addr_i),
		.frame_valid_o (frame_valid_o),
		.rd_valid_o    (rd_valid_o),
		.rd_data_o     (rd_data_o)
	);

endmodule

/* verification/lag_correlator_properties.sv */
`timescale 1ns/1ps

module lag_correlator_properties (
	input logic clk,
	input logic rst_n_i,
	input logic sample_stb_i,
	input logic enable_i,
	input logic rd_stb_i,
	input logic frame_valid_i,
	input logic rd_valid_i
);

	// Every read is answered on the next cycle
	a_read_answered: assert property (@(posedge clk) disable iff (!rst_n_i)
		rd_stb_i |=> rd_valid_i)
		else $error("rd_valid_o did not follow rd_stb_i");

	a_no_spurious_answer: assert property (@(posedge clk) disable iff (!rst_n_i)
		rd_valid_i |-> $past(rd_stb_i))
		else $error("rd_valid_o high without a read strobe one cycle earlier");

	a_frame_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		frame_valid_i |=> !frame_valid_i)
		else $error("frame_valid_o high on two consecutive cycles");

	a_strobe_spacing: assert property (@(posedge clk) disable iff (!rst_n_i)
		sample_stb_i |=> !sample_stb_i)
		else $error("sample_stb_i high on two consecutive cycles");

	// Disabled long enough for any pending dump to be gone
	a_quiet_when_disabled: assert property (@(posedge clk) disable iff (!rst_n_i)
		(!enable_i && $past(!enable_i) && $past(!enable_i, 2)) |-> !frame_valid_i)
		else $error("frame_valid_o rose while enable_i was low");

endmodule

bind lag_correlator_top lag_correlator_properties u_props (
	.clk           (clk),
	.rst_n_i       (rst_n_i),
	.sample_stb_i  (sample_stb_i),
	.enable_i      (enable_i),
	.rd_stb_i      (rd_stb_i),
	.frame_valid_i (frame_valid_o),
	.rd_valid_i    (rd_valid_o)
);

/* verification/tb_lag_correlator.sv */
`timescale 1ns/1ps

module tb_lag_correlator;

	localparam int SW = corr_pkg::SAMPLE_WIDTH;
	localparam int NI = corr_pkg::NUM_INPUTS;
	localparam int NL = corr_pkg::NUM_LAGS;
	localparam int NW = corr_pkg::NUM_WORDS;
	localparam int VEC_W = NI * SW;

	// Saturation value, all ones in the accumulator width
	localparam int MAX_VAL = (1 << corr_pkg::ACC_WIDTH) - 1;

	localparam int FRAME_LATENCY = 3;
	localparam int FRAME_TIMEOUT = 8;

	// Run length estimate in clock cycles
	localparam int SET_CYCLES = 2;
	localparam int BANK_CYCLES = NW * 2 + FRAME_TIMEOUT;
	localparam int RESET_CYCLES = 6;
	localparam int TOTAL_SETS = 16 + 6 + 500 + 60 + 21;
	localparam int TOTAL_BANKS = 4 + 1 + 2 + 3 + 3;
	localparam int TEST_CYCLES = 6 * RESET_CYCLES + 40 + TOTAL_SETS * SET_CYCLES
		+ TOTAL_BANKS * BANK_CYCLES;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4 + 100;

	logic                                clk;
	logic                                rst_n_i;
	logic                                sample_stb_i;
	logic [VEC_W-1:0]                    samples_i;
	logic                                enable_i;
	logic [corr_pkg::INT_LEN_WIDTH-1:0]  int_len_i;
	logic                                rd_stb_i;
	logic [corr_pkg::ADDR_WIDTH-1:0]     rd_addr_i;
	logic                                frame_valid_o;
	logic                                rd_valid_o;
	logic [corr_pkg::ACC_WIDTH-1:0]      rd_data_o;

	// Reference model state, tap 0 is the newest sample
	int hist [NI][NL];
	int model_acc [NW];
	int expected_bank [NW];
	int set_count;
	int cur_int_len;
	bit model_enable;
	bit frame_due;

	int cycle_cnt = 0;
	int last_stb_cycle;

	lag_correlator_top u_dut (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.sample_stb_i  (sample_stb_i),
		.samples_i     (samples_i),
		.enable_i      (enable_i),
		.int_len_i     (int_len_i),
		.rd_stb_i      (rd_stb_i),
		.rd_addr_i     (rd_addr_i),
		.frame_valid_o (frame_valid_o),
		.rd_valid_o    (rd_valid_o),
		.rd_data_o     (rd_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped after a failure");
	endtask

	task automatic check_value(input string test_name, input string what,
			input int expected, input int actual);
		if (expected !== actual) begin
			$display("Error: %s: %s expected %0d actual %0d", test_name, what, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	function automatic void clear_model();
		for (int i = 0; i < NI; i++) begin
			for (int k = 0; k < NL; k++) begin
				hist[i][k] = 0;
			end
		end
		for (int w = 0; w < NW; w++) begin
			model_acc[w] = 0;
			expected_bank[w] = 0;
		end
		set_count = 0;
		model_enable = 1'b0;
		frame_due = 1'b0;
	endfunction

	// Shift the history, then add a[0] * b[k] for every baseline and lag
	function automatic void update_model(input logic [VEC_W-1:0] vec);
		int a;
		int b;
		int w;
		int sum;
		for (int i = 0; i < NI; i++) begin
			for (int k = NL - 1; k > 0; k--) begin
				hist[i][k] = hist[i][k-1];
			end
			hist[i][0] = int'(vec[i*SW +: SW]);
		end
		if (model_enable) begin
			for (int bl = 0; bl < corr_pkg::NUM_BASELINES; bl++) begin
				a = corr_pkg::BASELINE_A[bl];
				b = corr_pkg::BASELINE_B[bl];
				for (int k = 0; k < NL; k++) begin
					w = bl * NL + k;
					sum = model_acc[w] + hist[a][0] * hist[b][k];
					model_acc[w] = (sum > MAX_VAL) ? MAX_VAL : sum;
				end
			end
			set_count++;
			if (set_count == cur_int_len) begin
				for (int i = 0; i < NW; i++) begin
					expected_bank[i] = model_acc[i];
					model_acc[i] = 0;
				end
				set_count = 0;
				frame_due = 1'b1;
			end
		end
	endfunction

	task automatic apply_reset();
		rst_n_i = 1'b0;
		sample_stb_i = 1'b0;
		samples_i = '0;
		enable_i = 1'b0;
		rd_stb_i = 1'b0;
		rd_addr_i = '0;
		repeat (3) @(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);
		clear_model();
	endtask

	task automatic start_integration(input int len);
		int_len_i = corr_pkg::INT_LEN_WIDTH'(len);
		cur_int_len = len;
		enable_i = 1'b1;
		model_enable = 1'b1;
		@(negedge clk);
	endtask

	task automatic set_enable(input bit en);
		enable_i = en;
		model_enable = en;
		if (!en) begin
			for (int w = 0; w < NW; w++) begin
				model_acc[w] = 0;
			end
			set_count = 0;
		end
		@(negedge clk);
	endtask

	task automatic read_word(input string test_name, input int addr, output int data);
		rd_stb_i = 1'b1;
		rd_addr_i = corr_pkg::ADDR_WIDTH'(addr);
		@(negedge clk);
		rd_stb_i = 1'b0;
		check_value(test_name, "rd_valid_o one cycle after read", 1, int'(rd_valid_o));
		data = int'(rd_data_o);
		@(negedge clk);
		check_value(test_name, "rd_valid_o after read answered", 0, int'(rd_valid_o));
	endtask

	task automatic read_bank(input string test_name);
		int data;
		for (int w = 0; w < NW; w++) begin
			read_word(test_name, w, data);
			check_value(test_name, $sformatf("word %0d", w), expected_bank[w], data);
		end
	endtask

	task automatic check_frame(input string test_name);
		int waited;
		waited = 0;
		while (frame_valid_o !== 1'b1) begin
			if (waited == FRAME_TIMEOUT) begin
				fail_run($sformatf("%s: frame_valid_o never rose after the last set", test_name));
			end
			@(negedge clk);
			waited++;
		end
		check_value(test_name, "cycles from strobe to frame_valid_o", FRAME_LATENCY,
			cycle_cnt - last_stb_cycle);
		@(negedge clk);
		check_value(test_name, "frame_valid_o one cycle later", 0, int'(frame_valid_o));
		read_bank(test_name);
		frame_due = 1'b0;
	endtask

	// One strobe plus one idle cycle
	task automatic run_set(input string test_name, input logic [VEC_W-1:0] vec);
		sample_stb_i = 1'b1;
		samples_i = vec;
		last_stb_cycle = cycle_cnt;
		update_model(vec);
		@(negedge clk);
		sample_stb_i = 1'b0;
		check_value(test_name, "frame_valid_o in strobe cycle", 0, int'(frame_valid_o));
		@(negedge clk);
		check_value(test_name, "frame_valid_o in idle cycle", 0, int'(frame_valid_o));
		if (frame_due) begin
			check_frame(test_name);
		end
	endtask

	task automatic test_reset_state();
		int data;
		apply_reset();
		repeat (10) begin
			check_value("test_reset_state", "frame_valid_o", 0, int'(frame_valid_o));
			check_value("test_reset_state", "rd_valid_o", 0, int'(rd_valid_o));
			@(negedge clk);
		end
		read_word("test_reset_state", 0, data);
		check_value("test_reset_state", "word 0", 0, data);
		read_word("test_reset_state", 31, data);
		check_value("test_reset_state", "unmapped word 31", 0, data);
	endtask

	task automatic test_constant_inputs();
		int data;
		int expected;
		apply_reset();
		start_integration(8);
		for (int f = 0; f < 2; f++) begin
			repeat (8) run_set("test_constant_inputs", {VEC_W{1'b1}});
			// First frame still sees reset zeros in the deeper taps
			for (int w = 0; w < NW; w++) begin
				expected = (f == 0) ? 9 * (8 - (w % NL)) : 72;
				read_word("test_constant_inputs", w, data);
				check_value("test_constant_inputs", $sformatf("frame %0d word %0d", f, w),
					expected, data);
			end
		end
		// Bank is full of nonzero words here
		read_word("test_constant_inputs", NW, data);
		check_value("test_constant_inputs", $sformatf("unmapped word %0d", NW), 0, data);
	endtask

	task automatic test_lag_alignment();
		int data;
		apply_reset();
		start_integration(6);
		run_set("test_lag_alignment", 8'b0000_0000);
		// Input 1 leads, so input 0 meets it one tap later
		run_set("test_lag_alignment", 8'b0000_1100);
		run_set("test_lag_alignment", 8'b0000_0010);
		repeat (3) run_set("test_lag_alignment", 8'b0000_0000);
		read_word("test_lag_alignment", 1, data);
		check_value("test_lag_alignment", "baseline (0,1) lag 1", 6, data);
		read_word("test_lag_alignment", 0, data);
		check_value("test_lag_alignment", "baseline (0,1) lag 0", 0, data);
	endtask

	task automatic test_saturation();
		int data;
		apply_reset();
		start_integration(500);
		repeat (500) run_set("test_saturation", {VEC_W{1'b1}});
		for (int w = 0; w < NW; w++) begin
			read_word("test_saturation", w, data);
			check_value("test_saturation", $sformatf("word %0d", w), MAX_VAL, data);
		end
	endtask

	task automatic test_random_frames();
		apply_reset();
		start_integration(20);
		repeat (60) run_set("test_random_frames", VEC_W'($urandom));
	endtask

	task automatic test_enable_clear();
		apply_reset();
		start_integration(8);
		repeat (8) run_set("test_enable_clear", VEC_W'($urandom));
		repeat (3) run_set("test_enable_clear", VEC_W'($urandom));
		set_enable(1'b0);
		repeat (2) run_set("test_enable_clear", VEC_W'($urandom));
		// Bank must still hold the first frame
		read_bank("test_enable_clear");
		set_enable(1'b1);
		repeat (8) run_set("test_enable_clear", VEC_W'($urandom));
	endtask

	initial begin
		rst_n_i = 1'b0;
		sample_stb_i = 1'b0;
		samples_i = '0;
		enable_i = 1'b0;
		int_len_i = 16'd1;
		rd_stb_i = 1'b0;
		rd_addr_i = '0;
		last_stb_cycle = 0;
		cur_int_len = 1;
		clear_model();
		void'($urandom(32'hfec9));

		test_reset_state();
		test_constant_inputs();
		test_lag_alignment();
		test_saturation();
		test_random_frames();
		test_enable_clear();

		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		fail_run($sformatf("Watchdog expired after %0d cycles, run did not finish",
			WATCHDOG_CYCLES));
	end

endmodule

/* files.f */
src/corr_pkg.sv
src/sample_delay_line.sv
src/baseline_correlator.sv
src/integration_control.sv
src/correlation_readout.sv
src/lag_correlator_top.sv
verification/lag_correlator_properties.sv
verification/tb_lag_correlator.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the lag correlator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_lag_correlator \
	-f files.f \
	--Mdir obj_dir \
	-o tb_lag_correlator

# Nonzero exit status on any $fatal or assertion failure
./obj_dir/tb_lag_correlator
